/* logic/mipsPkg.sv */
// Integer subset only; opcodes and functs outside the enums decode as a no-operation
package mipsPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;

  localparam wordT resetPc = 32'h0000_0000;
  localparam wordT pcStep  = 32'd4;

  // Kept primary opcodes
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opAddi  = 6'h08,
    opAndi  = 6'h0c,
    opOri   = 6'h0d,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // Kept R-type functs
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnXor = 6'h26,
    fnNor = 6'h27,
    fnSlt = 6'h2a
  } functT;

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluXor = 3'b100,
    aluNor = 3'b101,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpT;

  // Execute operand source
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSelT;

  // --------------------------------------------------------------------
  // Stage structs
  // --------------------------------------------------------------------
  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memWrite;
    logic  aluSrc;     // Second operand is the immediate
    logic  regDst;     // Destination is rd
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    srcA;
    wordT    srcB;
    wordT    imm;      // Already extended
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
  } decExT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    wordT    aluOut;
    wordT    writeData;
    regAddrT writeReg;
  } exMemT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    wordT    aluOut;
    wordT    readData;
    regAddrT writeReg;
  } memWbT;

  typedef struct packed {
    logic memWrite;
    wordT addr;
    wordT writeData;
  } dataReqT;

endpackage

/* logic/fetchStage.sv */
// Instruction memory must answer in the same cycle; stall freezes the PC and the decode register
`timescale 1ns/1ps

module fetchStage (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall,
  input  logic          takeBranch,
  input  mipsPkg::wordT targetPc,
  input  mipsPkg::wordT instr,
  output mipsPkg::wordT pc,
  output mipsPkg::wordT pcPlus4D,
  output mipsPkg::wordT instrD
);
  import mipsPkg::*;

  wordT pcPlus4;
  wordT pcNext;

  assign pcPlus4 = pc + pcStep;
  assign pcNext  = takeBranch ? targetPc : pcPlus4;  // Redirect from decode

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= resetPc;
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

  // Fetch/decode register; all zero is sll $0 and decodes as a no-operation
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcPlus4D <= '0;
      instrD   <= '0;
    end else if (!stall) begin
      pcPlus4D <= pcPlus4;
      instrD   <= instr;   // Delay slot lands here on a taken branch
    end
  end

endmodule

/* logic/decodeStage.sv */
// Register file writes on the falling edge so a value written back is readable in the same cycle
`timescale 1ns/1ps

module decodeStage (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              flush,
  input  mipsPkg::wordT     instrD,
  input  mipsPkg::wordT     pcPlus4D,
  input  logic              fwdA,
  input  logic              fwdB,
  input  mipsPkg::wordT     memAluOut,
  input  logic              wbRegWrite,
  input  mipsPkg::regAddrT  wbReg,
  input  mipsPkg::wordT     wbResult,
  output logic              takeBranch,
  output mipsPkg::wordT     targetPc,
  output mipsPkg::regAddrT  rs,
  output mipsPkg::regAddrT  rt,
  output logic              isBranch,
  output mipsPkg::decExT    decEx
);
  import mipsPkg::*;

  opcodeT  op;
  functT   funct;
  regAddrT rd;
  ctrlT    ctrl;
  logic    zeroExt;
  logic    isJump;
  logic    equal;
  wordT    imm;
  wordT    rfA, rfB;
  wordT    cmpA, cmpB;
  wordT    branchTarget, jumpTarget;
  decExT   decNext;
  wordT    regs [32];

  assign op    = opcodeT'(instrD[31:26]);
  assign funct = functT'(instrD[5:0]);
  assign rs    = instrD[25:21];
  assign rt    = instrD[20:16];
  assign rd    = instrD[15:11];

  // --------------------------------------------------------------------
  // Control decode
  // --------------------------------------------------------------------
  always_comb begin
    ctrl    = '0;
    zeroExt = 1'b0;
    case (op)
      opRtype: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnXor:   ctrl.aluOp = aluXor;
          fnNor:   ctrl.aluOp = aluNor;
          fnSlt:   ctrl.aluOp = aluSlt;
          default: ctrl       = '0;     // Unknown funct decodes as a no-operation
        endcase
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opAndi, opOri: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = (op == opAndi) ? aluAnd : aluOr;
        zeroExt       = 1'b1;            // Logical immediates zero-extend
      end
      default: ctrl = '0;                // Branches, J and anything else write nothing
    endcase
  end

  assign imm = zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

  // Register file with register 0 reading as zero
  always_ff @(negedge clk) begin
    if (wbRegWrite) begin
      regs[wbReg] <= wbResult;
    end
  end

  assign rfA = (rs != '0) ? regs[rs] : '0;
  assign rfB = (rt != '0) ? regs[rt] : '0;

  // --------------------------------------------------------------------
  // Branch resolution
  // --------------------------------------------------------------------
  assign cmpA  = fwdA ? memAluOut : rfA;
  assign cmpB  = fwdB ? memAluOut : rfB;
  assign equal = (cmpA == cmpB);

  assign isBranch = (op == opBeq) || (op == opBne);
  assign isJump   = (op == opJ);

  assign branchTarget = pcPlus4D + {imm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};
  assign targetPc     = isJump ? jumpTarget : branchTarget;

  // No redirect while held so the branch retries next cycle
  assign takeBranch = !stall &&
                      (isJump || (op == opBeq && equal) || (op == opBne && !equal));

  always_comb begin
    decNext.ctrl = ctrl;
    decNext.srcA = rfA;
    decNext.srcB = rfB;
    decNext.imm  = imm;
    decNext.rs   = rs;
    decNext.rt   = rt;
    decNext.rd   = rd;
  end

  // Decode/execute register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      decEx <= '0;
    end else if (flush) begin
      decEx <= '0;     // Bubble into execute
    end else begin
      decEx <= decNext;
    end
  end

endmodule

/* logic/hazardUnit.sv */
// Purely combinational; branch operands are forwarded only from memory, never from a load
`timescale 1ns/1ps

module hazardUnit (
  input  mipsPkg::regAddrT rsD,
  input  mipsPkg::regAddrT rtD,
  input  logic             isBranch,
  input  mipsPkg::decExT   decEx,
  input  mipsPkg::exMemT   exMem,
  input  mipsPkg::memWbT   memWb,
  output logic             stall,
  output logic             flush,
  output logic             fwdA,
  output logic             fwdB,
  output mipsPkg::fwdSelT  fwdSelA,
  output mipsPkg::fwdSelT  fwdSelB
);
  import mipsPkg::*;

  regAddrT writeRegE;
  logic    loadUse;
  logic    branchStall;

  assign writeRegE = decEx.ctrl.regDst ? decEx.rd : decEx.rt;

  // Decode compare forwarding
  assign fwdA = (rsD != '0) && exMem.regWrite && (rsD == exMem.writeReg);
  assign fwdB = (rtD != '0) && exMem.regWrite && (rtD == exMem.writeReg);

  // Execute forwarding with memory ahead of writeback
  always_comb begin
    fwdSelA = fwdNone;
    fwdSelB = fwdNone;
    if (decEx.rs != '0) begin
      if (exMem.regWrite && decEx.rs == exMem.writeReg)      fwdSelA = fwdMem;
      else if (memWb.regWrite && decEx.rs == memWb.writeReg) fwdSelA = fwdWb;
    end
    if (decEx.rt != '0) begin
      if (exMem.regWrite && decEx.rt == exMem.writeReg)      fwdSelB = fwdMem;
      else if (memWb.regWrite && decEx.rt == memWb.writeReg) fwdSelB = fwdWb;
    end
  end

  assign loadUse = decEx.ctrl.memToReg && (writeRegE != '0) &&
                   (writeRegE == rsD || writeRegE == rtD);

  // Operand still in execute, or a load still in memory
  assign branchStall = isBranch &&
    ((decEx.ctrl.regWrite && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
     (exMem.memToReg && exMem.writeReg != '0 &&
      (exMem.writeReg == rsD || exMem.writeReg == rtD)));

  assign stall = loadUse || branchStall;
  assign flush = stall;   // Holding decode leaves a bubble in execute

endmodule

/* logic/executeStage.sv */
// ALU only, no shifter; SLT is a signed compare returning 0 or 1
`timescale 1ns/1ps

module executeStage (
  input  logic            clk,
  input  logic            reset,
  input  mipsPkg::decExT  decEx,
  input  mipsPkg::fwdSelT fwdSelA,
  input  mipsPkg::fwdSelT fwdSelB,
  input  mipsPkg::wordT   memAluOut,
  input  mipsPkg::wordT   wbResult,
  output mipsPkg::exMemT  exMem
);
  import mipsPkg::*;

  wordT    opA, opB;
  wordT    aluB;
  wordT    aluResult;
  regAddrT writeReg;
  exMemT   exNext;

  // Operand forwarding
  always_comb begin
    case (fwdSelA)
      fwdMem:  opA = memAluOut;
      fwdWb:   opA = wbResult;
      default: opA = decEx.srcA;
    endcase
    case (fwdSelB)
      fwdMem:  opB = memAluOut;
      fwdWb:   opB = wbResult;
      default: opB = decEx.srcB;
    endcase
  end

  assign aluB = decEx.ctrl.aluSrc ? decEx.imm : opB;

  // --------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------
  always_comb begin
    case (decEx.ctrl.aluOp)
      aluAnd:  aluResult = opA & aluB;
      aluOr:   aluResult = opA | aluB;
      aluAdd:  aluResult = opA + aluB;
      aluSub:  aluResult = opA - aluB;
      aluXor:  aluResult = opA ^ aluB;
      aluNor:  aluResult = ~(opA | aluB);
      aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(aluB)};
      default: aluResult = '0;
    endcase
  end

  assign writeReg = decEx.ctrl.regDst ? decEx.rd : decEx.rt;

  always_comb begin
    exNext.regWrite  = decEx.ctrl.regWrite;
    exNext.memToReg  = decEx.ctrl.memToReg;
    exNext.memWrite  = decEx.ctrl.memWrite;
    exNext.aluOut    = aluResult;
    exNext.writeData = opB;        // Store data after forwarding
    exNext.writeReg  = writeReg;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exMem <= '0;
    end else begin
      exMem <= exNext;
    end
  end

endmodule

/* logic/writebackStage.sv */
// Load data must arrive in the same cycle as its address; no byte or halfword loads
`timescale 1ns/1ps

module writebackStage (
  input  logic             clk,
  input  logic             reset,
  input  mipsPkg::exMemT   exMem,
  input  mipsPkg::wordT    readData,
  output mipsPkg::memWbT   memWb,
  output logic             wbRegWrite,
  output mipsPkg::regAddrT wbReg,
  output mipsPkg::wordT    wbResult
);
  import mipsPkg::*;

  // Memory/writeback register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      memWb <= '0;
    end else begin
      memWb.regWrite <= exMem.regWrite;
      memWb.memToReg <= exMem.memToReg;
      memWb.aluOut   <= exMem.aluOut;
      memWb.readData <= readData;      // Loaded word
      memWb.writeReg <= exMem.writeReg;
    end
  end

  assign wbRegWrite = memWb.regWrite;
  assign wbReg      = memWb.writeReg;
  assign wbResult   = memWb.memToReg ? memWb.readData : memWb.aluOut;

endmodule

/* logic/mipsCore.sv */
// Both memories are combinational with no handshake; data memory writes on the rising edge
`timescale 1ns/1ps

module mipsCore (
  input  logic             clk,
  input  logic             reset,
  output mipsPkg::wordT    pc,
  input  mipsPkg::wordT    instr,
  output mipsPkg::dataReqT dataReq,
  input  mipsPkg::wordT    readData
);
  import mipsPkg::*;

  logic    stall, flush;
  logic    takeBranch;
  wordT    targetPc;
  wordT    pcPlus4D, instrD;
  regAddrT rsD, rtD;
  logic    isBranch;
  logic    fwdA, fwdB;
  fwdSelT  fwdSelA, fwdSelB;
  decExT   decEx;
  exMemT   exMem;
  memWbT   memWb;
  logic    wbRegWrite;
  regAddrT wbReg;
  wordT    wbResult;

  // --------------------------------------------------------------------
  // Stages
  // --------------------------------------------------------------------
  fetchStage fetch_i (.clk, .reset, .stall, .takeBranch, .targetPc, .instr,
                      .pc, .pcPlus4D, .instrD);

  decodeStage decode_i (.clk, .reset, .stall, .flush, .instrD, .pcPlus4D, .fwdA, .fwdB,
                        .memAluOut(exMem.aluOut), .wbRegWrite, .wbReg, .wbResult,
                        .takeBranch, .targetPc, .rs(rsD), .rt(rtD), .isBranch, .decEx);

  hazardUnit hazard_i (.rsD, .rtD, .isBranch, .decEx, .exMem, .memWb,
                       .stall, .flush, .fwdA, .fwdB, .fwdSelA, .fwdSelB);

  executeStage execute_i (.clk, .reset, .decEx, .fwdSelA, .fwdSelB,
                          .memAluOut(exMem.aluOut), .wbResult, .exMem);

  writebackStage writeback_i (.clk, .reset, .exMem, .readData, .memWb,
                              .wbRegWrite, .wbReg, .wbResult);

  // Memory stage is just the data port
  assign dataReq.memWrite  = exMem.memWrite;
  assign dataReq.addr      = exMem.aluOut;
  assign dataReq.writeData = exMem.writeData;

endmodule

/* tb/mipsCore_asserts.sv */
// Bound into mipsCore; all checks hold only while reset is low and use the core clock
`timescale 1ns/1ps

module mipsCoreAsserts (
  input logic             clk,
  input logic             reset,
  input mipsPkg::wordT    pc,
  input mipsPkg::dataReqT dataReq,
  input logic             stall
);

  int failCount = 0;   // Assertion failures so far

  memWriteKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(dataReq.memWrite))
    else begin
      failCount++;
      $error("Data memory write enable is unknown");
    end

  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else begin
      failCount++;
      $error("PC is not word aligned");
    end

  // Load feeding a branch is the longest hold
  stallBounded: assert property (@(posedge clk) disable iff (reset)
    !(stall && $past(stall) && $past(stall, 2)))
    else begin
      failCount++;
      $error("Stall held for more than two cycles");
    end

endmodule

bind mipsCore mipsCoreAsserts asserts_i (.clk, .reset, .pc, .dataReq, .stall);

/* tb/mipsCoreTb.sv */
// Programs are hand-assembled into 64-word memories; every test restarts the core from reset
`timescale 1ns/1ps

module mipsCoreTb;
  import mipsPkg::*;

  logic    clk;
  logic    reset;
  wordT    pc;
  wordT    instr;
  dataReqT dataReq;
  wordT    readData;

  wordT        imem [64];
  wordT        dmem [64];
  wordT        prog [$];
  wordT        expAddr [$];
  wordT        expData [$];
  wordT        gotAddr [$];
  wordT        gotData [$];
  logic [31:0] lfsr;

  mipsCore mipsCore_i (.clk, .reset, .pc, .instr, .dataReq, .readData);

  // --------------------------------------------------------------------
  // Memory models
  // --------------------------------------------------------------------
  assign instr    = imem[pc[7:2]];             // Combinational fetch
  assign readData = dmem[dataReq.addr[7:2]];

  always #50 clk = ~clk;

  // Write port logging every store in issue order
  always @(posedge clk) begin
    if (!reset && dataReq.memWrite) begin
      dmem[dataReq.addr[7:2]] <= dataReq.writeData;
      gotAddr.push_back(dataReq.addr);
      gotData.push_back(dataReq.writeData);
    end
  end

  // Assertion failures inside the core end the run at the next falling edge
  always @(negedge clk) begin
    if (mipsCore_i.asserts_i.failCount != 0) begin
      failRun("An assertion inside the core failed");
    end
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  function automatic wordT randomBits(input int n);
    wordT r;
    logic fb;
    int   k;
    r = '0;
    for (k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic wordT rType(input functT fn, input regAddrT rd, input regAddrT rs,
                                 input regAddrT rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT iType(input opcodeT op, input regAddrT rt, input regAddrT rs,
                                 input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT jType(input int target);
    return {opJ, 26'(target)};  // Word index of the target
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopped on first error");
  endtask

  task automatic checkValue(input string what, input wordT got, input wordT exp);
    if (got !== exp) begin
      failRun($sformatf("[FAIL] %0d ns: %s got %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic storeReg(input regAddrT rt, input wordT addr, input wordT exp);
    prog.push_back(iType(opSw, rt, 5'd0, addr[15:0]));
    expAddr.push_back(addr);
    expData.push_back(exp);
  endtask

  // Wrong-path store that must never reach memory
  task automatic deadStore(input regAddrT rt, input wordT addr);
    prog.push_back(iType(opSw, rt, 5'd0, addr[15:0]));
  endtask

  task automatic storeResult(input wordT ins, input wordT addr, input wordT exp);
    prog.push_back(ins);
    storeReg(5'd3, addr, exp);  // Result always lands in r3
  endtask

  task automatic runProgram(input string name);
    int i;
    int cycles;
    prog.push_back(iType(opBeq, 5'd0, 5'd0, 16'hffff));  // Idle loop on itself
    prog.push_back(32'h0);
    @(posedge clk);
    #1 reset = 1'b1;
    for (i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      dmem[i] <= 32'hd000_0000 | wordT'(i << 2);
    end
    gotAddr.delete();
    gotData.delete();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (gotAddr.size() < expAddr.size()) begin
      @(negedge clk);
      cycles++;
      if (cycles > 1000) begin
        failRun($sformatf("Timeout in %s test, only %0d of %0d stores seen",
                          name, gotAddr.size(), expAddr.size()));
      end
    end
    for (i = 0; i < expAddr.size(); i++) begin
      checkValue($sformatf("%s store %0d address", name, i), gotAddr[i], expAddr[i]);
      checkValue($sformatf("%s store %0d data", name, i), gotData[i], expData[i]);
    end
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  // --------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------
  task automatic testAlu();
    logic [15:0] a1, b1, a2, b2, ia, io, ix;
    wordT        x, y;
    a1 = 16'(randomBits(16));
    b1 = 16'(randomBits(16));
    a2 = 16'(randomBits(16));
    b2 = 16'(randomBits(16));
    ia = 16'(randomBits(16));
    io = 16'(randomBits(16));
    ix = 16'(randomBits(16));
    x  = {{16{a1[15]}}, a1} | {16'h0, b1};   // ADDI sign-extends, ORI zero-extends
    y  = {{16{a2[15]}}, a2} | {16'h0, b2};
    prog.push_back(iType(opAddi, 5'd1, 5'd0, a1));
    prog.push_back(iType(opOri, 5'd1, 5'd1, b1));
    prog.push_back(iType(opAddi, 5'd2, 5'd0, a2));
    prog.push_back(iType(opOri, 5'd2, 5'd2, b2));
    storeResult(rType(fnAdd, 5'd3, 5'd1, 5'd2), 32'h00, x + y);
    storeResult(rType(fnSub, 5'd3, 5'd1, 5'd2), 32'h04, x - y);
    storeResult(rType(fnAnd, 5'd3, 5'd1, 5'd2), 32'h08, x & y);
    storeResult(rType(fnOr, 5'd3, 5'd1, 5'd2), 32'h0c, x | y);
    storeResult(rType(fnXor, 5'd3, 5'd1, 5'd2), 32'h10, x ^ y);
    storeResult(rType(fnNor, 5'd3, 5'd1, 5'd2), 32'h14, ~(x | y));
    storeResult(rType(fnSlt, 5'd3, 5'd1, 5'd2), 32'h18,
                ($signed(x) < $signed(y)) ? 32'd1 : 32'd0);
    storeResult(rType(fnSlt, 5'd3, 5'd2, 5'd1), 32'h1c,
                ($signed(y) < $signed(x)) ? 32'd1 : 32'd0);
    storeResult(rType(fnSlt, 5'd3, 5'd1, 5'd1), 32'h20, 32'd0);  // Equal is not less
    storeResult(iType(opAndi, 5'd3, 5'd1, ia), 32'h24, x & {16'h0, ia});
    storeResult(iType(opOri, 5'd3, 5'd1, io), 32'h28, x | {16'h0, io});
    storeResult(iType(opAddi, 5'd3, 5'd2, ix), 32'h2c, y + {{16{ix[15]}}, ix});
    runProgram("alu");
  endtask

  task automatic testForwarding();
    logic [15:0] v;
    wordT        a, b, c, d, e, f;
    v = 16'(randomBits(16));
    a = {{16{v[15]}}, v};
    b = a + a;
    c = b - a;
    d = c ^ b;
    e = ~(d | a);
    f = e & c;
    prog.push_back(iType(opAddi, 5'd4, 5'd0, v));  // Back-to-back dependent chain
    prog.push_back(rType(fnAdd, 5'd5, 5'd4, 5'd4));
    prog.push_back(rType(fnSub, 5'd6, 5'd5, 5'd4));
    prog.push_back(rType(fnXor, 5'd7, 5'd6, 5'd5));
    prog.push_back(rType(fnNor, 5'd8, 5'd7, 5'd4));
    storeReg(5'd8, 32'h40, e);                     // Store data from memory stage
    prog.push_back(rType(fnAnd, 5'd9, 5'd8, 5'd6));
    storeReg(5'd9, 32'h44, f);
    runProgram("forwarding");
  endtask

  task automatic testLoadUse();
    logic [15:0] v, k;
    wordT        a, s;
    v = 16'(randomBits(16));
    k = 16'(randomBits(16));
    a = {{16{v[15]}}, v};
    s = a + {{16{k[15]}}, k};
    prog.push_back(iType(opAddi, 5'd10, 5'd0, v));
    storeReg(5'd10, 32'h50, a);
    prog.push_back(iType(opLw, 5'd11, 5'd0, 16'h0050));
    prog.push_back(iType(opAddi, 5'd12, 5'd11, k));  // Uses the load right away
    storeReg(5'd12, 32'h54, s);
    prog.push_back(iType(opLw, 5'd13, 5'd0, 16'h0050));
    storeReg(5'd13, 32'h58, a);                      // Load feeds store data
    prog.push_back(iType(opLw, 5'd14, 5'd0, 16'h0054));
    prog.push_back(rType(fnAdd, 5'd15, 5'd14, 5'd10));
    storeReg(5'd15, 32'h5c, s + a);
    runProgram("load-use");
  endtask

  // Offset 2 skips exactly one instruction after the delay slot
  task automatic testBranches();
    prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd5));
    prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'd5));
    prog.push_back(iType(opAddi, 5'd3, 5'd0, 16'd7));
    prog.push_back(iType(opBeq, 5'd2, 5'd1, 16'd2));   // Taken
    storeReg(5'd1, 32'h60, 32'd5);
    deadStore(5'd3, 32'h64);
    prog.push_back(iType(opBne, 5'd2, 5'd1, 16'd2));   // Not taken
    storeReg(5'd2, 32'h68, 32'd5);
    storeReg(5'd3, 32'h6c, 32'd7);
    prog.push_back(iType(opBne, 5'd3, 5'd1, 16'd2));   // Taken
    storeReg(5'd3, 32'h70, 32'd7);
    deadStore(5'd1, 32'h74);
    prog.push_back(iType(opBeq, 5'd3, 5'd1, 16'd2));   // Not taken
    storeReg(5'd1, 32'h78, 32'd5);
    storeReg(5'd2, 32'h7c, 32'd5);
    prog.push_back(iType(opLw, 5'd4, 5'd0, 16'h0060));
    prog.push_back(iType(opBeq, 5'd1, 5'd4, 16'd2));   // Taken after waiting on the load
    storeReg(5'd4, 32'h88, 32'd5);
    deadStore(5'd3, 32'h8c);
    storeReg(5'd3, 32'h90, 32'd7);
    runProgram("branch");
  endtask

  task automatic testJumpZero();
    prog.push_back(iType(opAddi, 5'd0, 5'd0, 16'h1234));  // Write to r0 is dropped
    storeReg(5'd0, 32'ha0, 32'd0);
    prog.push_back(iType(opOri, 5'd0, 5'd0, 16'h00ff));
    prog.push_back(rType(fnAdd, 5'd5, 5'd0, 5'd0));
    storeReg(5'd5, 32'ha4, 32'd0);
    prog.push_back(iType(opAddi, 5'd6, 5'd0, 16'h0033));
    prog.push_back(jType(prog.size() + 3));
    storeReg(5'd6, 32'ha8, 32'h33);                       // Delay slot
    deadStore(5'd0, 32'hac);
    storeReg(5'd6, 32'hb0, 32'h33);
    runProgram("jump");
  endtask

  initial begin
    int i;
    clk    = 1'b0;
    reset  = 1'b1;
    lfsr   = 32'h447b;
    for (i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
      dmem[i] <= 32'hd000_0000 | wordT'(i << 2);
    end
    testAlu();
    testForwarding();
    testLoadUse();
    testBranches();
    testJumpZero();
    if (mipsCore_i.asserts_i.failCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/mipsCore.sv
tb/mipsCore_asserts.sv
tb/mipsCoreTb.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= mipsCoreTb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
